/* include/fpuMulModel.svh */
`ifndef FPU_MUL_MODEL_SVH
`define FPU_MUL_MODEL_SVH

// Expected response from the exact product of the significands.
function automatic fpuRsp_t fpuMulModel(input fp16_t a, input fp16_t b);
  fpuRsp_t expRsp;
  longint  sigA;
  longint  sigB;
  longint  prod;
  longint  mant;
  longint  rem;
  longint  half;
  int      expA;
  int      expB;
  int      msb;
  int      expOut;
  int      shift;
  logic    inexact;
  sigA = (a.exp == 0) ? a.frac : (a.frac | 1024);
  sigB = (b.exp == 0) ? b.frac : (b.frac | 1024);
  expA = (a.exp == 0) ? 1 : a.exp;
  expB = (b.exp == 0) ? 1 : b.exp;
  prod = sigA * sigB;
  msb = 0;
  for (int i = 0; i < 22; i++) begin
    if (prod[i]) msb = i;
  end
  // Value is prod * 2^(expA+expB-50), clamp to the denormal exponent.
  expOut = msb + expA + expB - 35;
  if (expOut < 1) expOut = 1;
  shift = expOut + 25 - expA - expB;
  if (shift > 0) begin
    mant = prod >> shift;
    rem = prod & ((64'sd1 <<< shift) - 1);
    half = 64'sd1 <<< (shift - 1);
  end else begin
    mant = prod <<< (-shift);
    rem = 0;
    half = 1;
  end
  inexact = (rem != 0);
  if ((rem > half) || ((rem == half) && mant[0])) mant = mant + 1;
  if (mant == 2048) begin
    mant = 1024;
    expOut = expOut + 1;
  end
  expRsp = '0;
  expRsp.result.sign = a.sign ^ b.sign;
  if (expOut >= 31) begin
    expRsp.result.exp = 5'h1f;
    expRsp.opStatusFlags.overflow = 1'b1;
    inexact = 1'b1;
  end else begin
    expRsp.result.exp = (mant >= 1024) ? 5'(expOut) : 5'd0;
    expRsp.result.frac = mant[9:0];
    expRsp.opStatusFlags.underflow = (expRsp.result.exp == 0) && inexact;
  end
  expRsp.opStatusFlags.inexact = inexact;
  expRsp.condCodes.zero = (expRsp.result.exp == 0) && (expRsp.result.frac == 0);
  expRsp.condCodes.negative = expRsp.result.sign;
  return expRsp;
endfunction

`endif

/* tests/fpuMulTb.sv */
module fpuMulTb
  import fpuPkg::*;
  ();

  `include "fpuMulModel.svh"

  localparam int PERIOD = 4;
  localparam int RESET_CYCLES = 16;
  localparam int NUM_DIRECTED = 12;
  localparam int NUM_RANDOM = 2000;
  localparam int TOTAL_OPS = NUM_DIRECTED + NUM_RANDOM;

  logic    clock;
  logic    reset;
  logic    reqValid;
  logic    reqReady;
  fpuReq_t req;
  logic    rspValid;
  logic    rspReady;
  fpuRsp_t rsp;

  integer  seed;
  int      sent;
  int      rspCount;
  logic    reqTaken;
  logic    stalled;
  fpuRsp_t heldRsp;
  fpuRsp_t expRsp;
  fpuReq_t expOp;
  fpuRsp_t expQ[$];
  fpuReq_t opQ[$];

  // Ties to even, exact products, zeros, denormals and overflow.
  logic [31:0] directed [NUM_DIRECTED] = '{
    32'h3c01_3e00, 32'h3c03_3e00, 32'h3c00_3c00, 32'h0000_3c00,
    32'h8000_4000, 32'h0001_0001, 32'h0001_3c00, 32'h0400_3800,
    32'h7bff_7bff, 32'hfbff_4000, 32'h03ff_3c01, 32'h0200_0200
  };

  fpuCoproc #(.FRACW(10), .EXPW(5), .BIAS(15)) dut (
    .clock    (clock),
    .reset    (reset),
    .reqValid (reqValid),
    .reqReady (reqReady),
    .req      (req),
    .rspValid (rspValid),
    .rspReady (rspReady),
    .rsp      (rsp)
  );

  always #(PERIOD / 2) clock = ~clock;

  // Exponent field 31 is never driven.
  function automatic fp16_t randomOperand();
    fp16_t op;
    op.sign = $random(seed);
    op.exp = 5'({$random(seed)} % 31);
    op.frac = $random(seed);
    return op;
  endfunction

  task automatic stopOnFailure(input string what);
    $display("%s", what);
    $display("** FAIL **");
    $fatal(1);
  endtask

  task automatic checkResult(input fp16_t got, input fp16_t want, input fpuReq_t op);
    if (got !== want) begin
      $display("error at %0t: result %h, expected %h for %h * %h",
               $time, got, want, op.opA, op.opB);
      $display("** FAIL **");
      $fatal(1);
    end
  endtask

  task automatic checkCodes(input condCode_t got, input condCode_t want, input fpuReq_t op);
    if (got !== want) begin
      $display("error at %0t: condition codes %b, expected %b for %h * %h",
               $time, got, want, op.opA, op.opB);
      $display("** FAIL **");
      $fatal(1);
    end
  endtask

  task automatic checkFlags(input opStatusFlag_t got, input opStatusFlag_t want,
                            input fpuReq_t op);
    if (got !== want) begin
      $display("error at %0t: status flags %b, expected %b for %h * %h",
               $time, got, want, op.opA, op.opB);
      $display("** FAIL **");
      $fatal(1);
    end
  endtask

  // Watchdog sized from the number of operations.
  initial begin
    #((RESET_CYCLES + 40 * TOTAL_OPS) * PERIOD);
    $display("Run timed out before all responses arrived.");
    $display("** FAIL **");
    $fatal(1);
  end

  // Monitor and scoreboard, sampled at the falling edge.
  always @(negedge clock) begin
    if (!reset) begin
      if (rspValid && expQ.size() == 0) begin
        stopOnFailure("Response seen with no request outstanding.");
      end
      if (reqReady && expQ.size() != 0) begin
        stopOnFailure("Request channel ready while a response is pending.");
      end
      if (stalled) begin
        if (!rspValid) begin
          stopOnFailure("Response withdrawn before the host took it.");
        end
        checkResult(rsp.result, heldRsp.result, opQ[0]);
        checkCodes(rsp.condCodes, heldRsp.condCodes, opQ[0]);
        checkFlags(rsp.opStatusFlags, heldRsp.opStatusFlags, opQ[0]);
      end
      stalled = rspValid && !rspReady;
      heldRsp = rsp;
      if (rspValid && rspReady) begin
        expRsp = expQ.pop_front();
        expOp = opQ.pop_front();
        checkResult(rsp.result, expRsp.result, expOp);
        checkCodes(rsp.condCodes, expRsp.condCodes, expOp);
        checkFlags(rsp.opStatusFlags, expRsp.opStatusFlags, expOp);
        rspCount++;
      end
      if (reqValid && reqReady) begin
        expQ.push_back(fpuMulModel(req.opA, req.opB));
        opQ.push_back(req);
        reqTaken = 1'b1;
      end
    end
  end

  initial begin
    seed = 32'hdf5e_7369;
    clock = 1'b0;
    reset = 1'b1;
    reqValid = 1'b0;
    req = '0;
    rspReady = 1'b0;
    sent = 0;
    rspCount = 0;
    reqTaken = 1'b0;
    stalled = 1'b0;
    repeat (RESET_CYCLES) @(posedge clock);
    #1 reset = 1'b0;
    @(negedge clock);
    if (!reqReady || rspValid) begin
      stopOnFailure("Handshake outputs wrong after reset.");
    end
    // Requests and back-pressure from one seeded random sequence.
    while (rspCount < TOTAL_OPS) begin
      @(posedge clock);
      #1;
      rspReady = ({$random(seed)} % 3) != 0;
      if (reqTaken) begin
        reqValid = 1'b0;
        reqTaken = 1'b0;
      end
      if (!reqValid && sent < TOTAL_OPS && ({$random(seed)} % 4) != 0) begin
        if (sent < NUM_DIRECTED) begin
          req = directed[sent];
        end else begin
          req.opA = randomOperand();
          req.opB = randomOperand();
        end
        reqValid = 1'b1;
        sent++;
      end
    end
    repeat (4) @(posedge clock);
    @(negedge clock);
    if (!rspValid && reqReady) begin
      $display("** PASS **");
      $finish;
    end else begin
      $display("DUT not idle after the last response was taken.");
      $display("** FAIL **");
      $fatal(1);
    end
  end

endmodule : fpuMulTb

/* verilog/fpuCoproc.sv */
module fpuCoproc
  import fpuPkg::*;
  #(parameter int FRACW = 10,
    parameter int EXPW = 5,
    parameter int BIAS = 15)
  (input  logic    clock,
   input  logic    reset,
   input  logic    reqValid,
   output logic    reqReady,
   input  fpuReq_t req,
   output logic    rspValid,
   input  logic    rspReady,
   output fpuRsp_t rsp);

  fpuReq_t       reqReg;
  logic          busy;
  logic          mulStart;
  logic          mulDone;
  logic          reqAccept;
  logic          rspAccept;
  fp16_t         mulResult;
  condCode_t     mulCodes;
  opStatusFlag_t mulFlags;

  // One operation at a time, busy covers the multiply and the pending response.
  assign reqReady = ~busy;
  assign reqAccept = reqValid & reqReady;
  assign rspAccept = rspValid & rspReady;

  always_ff @(posedge clock, posedge reset) begin
    if (reset) begin
      busy <= 1'b0;
      mulStart <= 1'b0;
      rspValid <= 1'b0;
    end else begin
      mulStart <= reqAccept;
      if (reqAccept) begin
        busy <= 1'b1;
      end else if (rspAccept) begin
        busy <= 1'b0;
      end
      if (mulDone) begin
        rspValid <= 1'b1;
      end else if (rspAccept) begin
        rspValid <= 1'b0;
      end
    end
  end

  // Operands held until the next request, response held until taken.
  always_ff @(posedge clock) begin
    if (reqAccept) begin
      reqReg <= req;
    end
    if (mulDone) begin
      rsp <= '{result: mulResult, condCodes: mulCodes, opStatusFlags: mulFlags};
    end
  end

  fpuMul #(.FRACW(FRACW), .EXPW(EXPW), .BIAS(BIAS)) mulUnit (
    .clock         (clock),
    .reset         (reset),
    .start         (mulStart),
    .opA           (reqReg.opA),
    .opB           (reqReg.opB),
    .result        (mulResult),
    .condCodes     (mulCodes),
    .opStatusFlags (mulFlags),
    .done          (mulDone)
  );

endmodule : fpuCoproc

/* verilog/fpuMul.sv */
module fpuMul
  import fpuPkg::*;
  #(parameter int FRACW = 10,
    parameter int EXPW = 5,
    parameter int BIAS = 15)
  (input  logic          clock,
   input  logic          reset,
   input  logic          start,
   input  fp16_t         opA,
   input  fp16_t         opB,
   output fp16_t         result,
   output condCode_t     condCodes,
   output opStatusFlag_t opStatusFlags,
   output logic          done);

  logic                   outSign;
  logic [FRACW:0]         sigA;
  logic [FRACW:0]         sigB;
  logic [EXPW-1:0]        effExpA;
  logic [EXPW-1:0]        effExpB;
  logic signed [EXPW+1:0] expSum;
  logic [2*FRACW+1:0]     product;
  logic                   sigMulDone;
  logic                   sticky;
  fpuMulState_t           state;
  fpuMulState_t           nextState;

  assign outSign = opA.sign ^ opB.sign;

  // Hidden bit is 0 for a denormal or zero, which also counts as exponent 1.
  assign sigA = {opA.exp != '0, opA.frac};
  assign sigB = {opB.exp != '0, opB.frac};
  assign effExpA = (opA.exp == '0) ? EXPW'(1) : opA.exp;
  assign effExpB = (opB.exp == '0) ? EXPW'(1) : opB.exp;

  // Rebiased sum, two extra bits hold the underflow sign and the overflow range.
  assign expSum = (EXPW+2)'($signed({2'b00, effExpA}) + $signed({2'b00, effExpB}) - BIAS);

  radix16Mult #(.WIDTH(FRACW + 1)) sigMultiplier (
    .clock  (clock),
    .reset  (reset),
    .start  (start),
    .mulIn1 (sigA),
    .mulIn2 (sigB),
    .mulOut (product),
    .done   (sigMulDone)
  );

  // Bits under frac, guard and round.
  assign sticky = |product[FRACW-3:0];

  fpuNormalizer #(.FRACW(FRACW), .EXPW(EXPW)) mulNormalizer (
    .unnormSign    (outSign),
    .unnormInt     (product[2*FRACW+1:2*FRACW]),
    .unnormFrac    (product[2*FRACW-1:0]),
    .unnormExp     (expSum),
    .sticky        (sticky),
    .normOut       (result),
    .opStatusFlags (opStatusFlags)
  );

  assign condCodes.zero = (result.exp == '0) && (result.frac == '0);
  assign condCodes.negative = result.sign;

  always_ff @(posedge clock, posedge reset) begin
    if (reset) begin
      state <= MUL_IDLE;
    end else begin
      state <= nextState;
    end
  end

  always_comb begin
    nextState = state;
    unique case (state)
      MUL_IDLE: begin
        if (start) begin
          nextState = MUL_SIGCOMP;
        end
      end
      MUL_SIGCOMP: begin
        if (sigMulDone) begin
          nextState = MUL_DONE;
        end
      end
      MUL_DONE: nextState = MUL_IDLE;
      default: nextState = MUL_IDLE;
    endcase
  end

  // Result is stable for the whole done cycle.
  assign done = (state == MUL_DONE);

endmodule : fpuMul

/* verilog/fpuNormalizer.sv */
module fpuNormalizer
  import fpuPkg::*;
  #(parameter int FRACW = 10,
    parameter int EXPW = 5)
  (input  logic                   unnormSign,
   input  logic [1:0]             unnormInt,
   input  logic [2*FRACW-1:0]     unnormFrac,
   input  logic signed [EXPW+1:0] unnormExp,
   input  logic                   sticky,
   output fp16_t                  normOut,
   output opStatusFlag_t          opStatusFlags);

  localparam int EXP_MAX = (1 << EXPW) - 1;
  // Full product, working width (int, frac, guard, round) and the part below it.
  localparam int PW = 2 * FRACW + 2;
  localparam int WW = FRACW + 4;
  localparam int LOW = PW - WW;

  logic [PW-1:0]          fullMant;
  logic [PW-1:0]          shiftedMant;
  logic signed [EXPW+1:0] leadZeros;
  logic signed [EXPW+1:0] expLimit;
  logic signed [EXPW+1:0] leftShift;
  logic [WW-1:0]          normMant;
  logic signed [EXPW+1:0] normExp;
  logic                   normSticky;
  logic [EXPW+1:0]        rightShift;
  logic [WW-1:0]          denormMant;
  logic                   denormSticky;
  logic signed [EXPW+1:0] baseExp;
  logic [FRACW+1:0]       rounded;
  logic signed [EXPW+1:0] finalExp;
  logic                   roundUp;
  logic                   inexact;
  logic                   overflow;
  logic                   hasLead;

  assign fullMant = {unnormInt, unnormFrac};

  // Zeros between the binary point and the first set bit.
  always_comb begin
    leadZeros = (EXPW+2)'(PW - 1);
    for (int i = 0; i < PW - 1; i++) begin
      if (fullMant[i]) begin
        leadZeros = (EXPW+2)'(PW - 2 - i);
      end
    end
  end

  // Left shift never takes the exponent below 1.
  assign expLimit = unnormExp - (EXPW+2)'(1);
  assign leftShift = (unnormExp <= 1) ? '0 :
                     (leadZeros < expLimit) ? leadZeros : expLimit;
  assign shiftedMant = fullMant << leftShift;

  // Bring the integer part to exactly one.
  always_comb begin
    if (unnormInt[1]) begin
      normMant = fullMant[PW-1:LOW] >> 1;
      normSticky = sticky | fullMant[LOW];
      normExp = unnormExp + (EXPW+2)'(1);
    end else if (unnormInt[0]) begin
      normMant = fullMant[PW-1:LOW];
      normSticky = sticky;
      normExp = unnormExp;
    end else begin
      normMant = shiftedMant[PW-1:LOW];
      normSticky = |shiftedMant[LOW-1:0];
      normExp = unnormExp - leftShift;
    end
  end

  // Exponent below 1 becomes a denormal, shifted-out bits feed sticky.
  always_comb begin
    if (normExp < 1) begin
      rightShift = (EXPW+2)'(1 - normExp);
      denormMant = normMant >> rightShift;
      denormSticky = normSticky | ((normMant & ~({WW{1'b1}} << rightShift)) != '0);
      baseExp = (EXPW+2)'(1);
    end else begin
      rightShift = '0;
      denormMant = normMant;
      denormSticky = normSticky;
      baseExp = normExp;
    end
  end

  // Nearest-even on guard, round and sticky.
  assign roundUp = denormMant[1] & (denormMant[0] | denormSticky | denormMant[2]);
  assign rounded = {1'b0, denormMant[WW-2:2]} + (FRACW+2)'(roundUp);
  assign inexact = denormMant[1] | denormMant[0] | denormSticky;

  // A rounding carry renormalizes by one position.
  assign finalExp = baseExp + (EXPW+2)'(rounded[FRACW+1]);
  assign hasLead = rounded[FRACW+1] | rounded[FRACW];
  assign overflow = finalExp >= EXP_MAX;

  always_comb begin
    normOut.sign = unnormSign;
    if (overflow) begin
      normOut.exp = '1;
      normOut.frac = '0;
    end else if (hasLead) begin
      normOut.exp = finalExp[EXPW-1:0];
      normOut.frac = rounded[FRACW-1:0];
    end else begin
      normOut.exp = '0;
      normOut.frac = rounded[FRACW-1:0];
    end
  end

  assign opStatusFlags.overflow = overflow;
  assign opStatusFlags.underflow = ~overflow & ~hasLead & inexact;
  assign opStatusFlags.inexact = overflow | inexact;

endmodule : fpuNormalizer

/* verilog/fpuPkg.sv */
package fpuPkg;

  // Half-precision word as it travels on the buses.
  typedef struct packed {
    logic       sign;
    logic [4:0] exp;
    logic [9:0] frac;
  } fp16_t;

  // Condition codes derived from the final result.
  typedef struct packed {
    logic zero;
    logic negative;
  } condCode_t;

  // Status flags raised by rounding and range checks.
  typedef struct packed {
    logic overflow;
    logic underflow;
    logic inexact;
  } opStatusFlag_t;

  // One multiply request from the host.
  typedef struct packed {
    fp16_t opA;
    fp16_t opB;
  } fpuReq_t;

  // One multiply response to the host.
  typedef struct packed {
    fp16_t         result;
    condCode_t     condCodes;
    opStatusFlag_t opStatusFlags;
  } fpuRsp_t;

  // Multiply controller states.
  typedef enum logic [1:0] {
    MUL_IDLE,
    MUL_SIGCOMP,
    MUL_DONE
  } fpuMulState_t;

endpackage : fpuPkg

/* verilog/radix16Mult.sv */
module radix16Mult
  #(parameter int WIDTH = 11)
  (input  logic                 clock,
   input  logic                 reset,
   input  logic                 start,
   input  logic [WIDTH-1:0]     mulIn1,
   input  logic [WIDTH-1:0]     mulIn2,
   output logic [2*WIDTH-1:0]   mulOut,
   output logic                 done);

  // One 4-bit digit of the multiplier per cycle.
  localparam int ITERS = (WIDTH + 3) / 4;
  localparam int MW = 4 * ITERS;
  localparam int CW = $clog2(ITERS + 1);

  logic [2*WIDTH-1:0] multiplicand;
  logic [2*WIDTH-1:0] accum;
  logic [2*WIDTH-1:0] partial;
  logic [MW-1:0]      multiplier;
  logic [CW-1:0]      count;

  // Multiplicand is already shifted to the current digit position.
  assign partial = multiplicand * (2*WIDTH)'(multiplier[3:0]);
  assign mulOut = accum;

  // Iteration counter and the done pulse.
  always_ff @(posedge clock, posedge reset) begin
    if (reset) begin
      count <= '0;
      done <= 1'b0;
    end else if (start) begin
      count <= CW'(ITERS);
      done <= 1'b0;
    end else if (count != '0) begin
      count <= count - 1'b1;
      done <= (count == CW'(1));
    end else begin
      done <= 1'b0;
    end
  end

  // Shift-and-add datapath, product stays put once the count runs out.
  always_ff @(posedge clock) begin
    if (start) begin
      multiplicand <= {{WIDTH{1'b0}}, mulIn1};
      multiplier <= MW'(mulIn2);
      accum <= '0;
    end else if (count != '0) begin
      accum <= accum + partial;
      multiplicand <= multiplicand << 4;
      multiplier <= multiplier >> 4;
    end
  end

endmodule : radix16Mult

/* vlog.f */
+incdir+include
verilog/fpuPkg.sv
verilog/radix16Mult.sv
verilog/fpuNormalizer.sv
verilog/fpuMul.sv
verilog/fpuCoproc.sv
tests/fpuMulTb.sv
